/* bench/tb_pmd_video.sv */
`timescale 1ns/100ps

module tb_pmd_video;

	localparam int slot_cycles  = int'(video_pkg::slot_len);
	localparam int stb_cycle    = slot_cycles + int'(video_pkg::stb_count);  // In a fetch
	localparam int fetch_cycles = 2 * slot_cycles;                           // CPU plus video slot
	localparam int frame_cycles = int'(video_pkg::frame_fetches) * fetch_cycles;
	localparam int cycle_limit  = 18 * frame_cycles + 10000;

	logic                   osc;
	logic                   reset;
	color_pkg::color_mode_e mode;
	logic [7:0]             vram_data;
	logic [13:0]            vram_addr;
	logic                   pixel_clk;
	logic                   pixel;
	logic                   sd_n;
	logic                   sr_n;
	logic                   zat_n;
	logic [7:0]             vga_r;
	logic [7:0]             vga_g;
	logic [7:0]             vga_b;

	int         k;         // Cycles since reset release
	logic [7:0] cur_byte;  // Last byte loaded into the shifter
	logic [2:0] pix_idx;   // Pixel clocks since that load

	pmd_video_top dut0 (
		.osc        (osc),
		.reset      (reset),
		.color_mode (mode),
		.vram_data  (vram_data),
		.vram_addr  (vram_addr),
		.pixel_clk  (pixel_clk),
		.pixel      (pixel),
		.sd_n       (sd_n),
		.sr_n       (sr_n),
		.zat_n      (zat_n),
		.vga_r      (vga_r),
		.vga_g      (vga_g),
		.vga_b      (vga_b)
	);

	vram_model vram0 (
		.addr (vram_addr),
		.data (vram_data)
	);

	initial begin
		osc = 1'b0;
		forever #2 osc = ~osc;  // 4 ns period
	end

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------

	// Address moves once per fetch, in the cycle after stb
	function automatic video_pkg::vaddr_t addr_at(input int cyc);
		return video_pkg::vaddr_t'((cyc / fetch_cycles) % int'(video_pkg::frame_fetches));
	endfunction

	function automatic logic in_row(input video_pkg::vaddr_t a);
		return (a[5:0] >= video_pkg::row_set_pos) && (a[5:0] < video_pkg::row_clr_pos);
	endfunction

	function automatic logic zat_at(input int cyc);
		video_pkg::vaddr_t a;
		a = addr_at(cyc);
		return !a[14] && in_row(a);  // Lower 16K and inside the row window
	endfunction

	function automatic logic pclk_due(input int cyc);
		int c;
		c = cyc % slot_cycles;
		return (c == 0) || (c == 3) || (c == 6);
	endfunction

	function automatic logic [23:0] color_exp(input logic pix, input logic [1:0] at,
			input logic bl, input color_pkg::color_mode_e md);
		color_pkg::level_t r;
		color_pkg::level_t g;
		color_pkg::level_t b;
		r = '0;
		g = '0;
		b = '0;
		if (pix) begin
			case (md)
				color_pkg::green: g = (at[1] && !bl) ? 8'h00
					: (at[0] ? color_pkg::level_half : color_pkg::level_full);
				color_pkg::tv: begin
					case (at)
						2'd0:    r = color_pkg::tv_level_0;
						2'd1:    r = color_pkg::tv_level_1;
						2'd2:    r = color_pkg::tv_level_2;
						default: r = color_pkg::tv_level_3;
					endcase
					g = r;  // Grey
					b = r;
				end
				color_pkg::rgb: begin
					r = at[0] ? color_pkg::level_full : 8'h00;
					b = at[1] ? color_pkg::level_full : 8'h00;
					g = (at == 2'b00) ? color_pkg::level_half : 8'h00;
				end
				default: r = '0;  // Reserved mode is black
			endcase
		end
		return {r, g, b};
	endfunction

	// --------------------------------------------------
	// Checking and stepping
	// --------------------------------------------------

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic verify_outputs();
		video_pkg::vaddr_t a;
		logic              act;
		logic              pix;
		int                fr;
		a = addr_at(k);
		act = in_row(a);
		pix = (pix_idx < 3'd6) ? cur_byte[pix_idx] & zat_at(k) : 1'b0;
		fr = k / frame_cycles;
		compare_value("vram_addr", 32'(vram_addr), 32'(a[13:0]));
		compare_value("sd_n", 32'(sd_n), 32'(!((a[10:8] == 3'b000) && a[11] && a[14])));
		compare_value("sr_n", 32'(sr_n), 32'(!(a[2] && !a[3] && !act)));
		compare_value("zat_n", 32'(zat_n), 32'(zat_at(k)));
		if (k >= slot_cycles)  // Tap chain full after one slot
			compare_value("pixel_clk", 32'(pixel_clk), 32'(pclk_due(k)));
		compare_value("pixel", 32'(pixel), 32'(pix));
		compare_value("vga_rgb", 32'({vga_r, vga_g, vga_b}),
			32'(color_exp(pix, cur_byte[7:6], fr[video_pkg::blink_frame_bit], mode)));
	endtask

	// Update the model for the ending cycle, then check the next one
	task automatic advance_cycle();
		video_pkg::vaddr_t a;
		a = addr_at(k);
		if (k % fetch_cycles == stb_cycle) begin
			cur_byte = vram0.mem[a[13:0]];  // Byte taken at this strobe
			pix_idx  = 3'd0;
		end else if (pclk_due(k) && pix_idx < 3'd6) begin
			pix_idx = pix_idx + 3'd1;
		end
		@(negedge osc);
		k++;
		verify_outputs();
	endtask

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------

	task automatic check_frame_timing();
		int   falls;
		int   first_fall;
		int   pcnt;
		logic sd_prev;
		falls = 0;
		first_fall = 0;
		pcnt = -1;  // No full slot seen yet
		sd_prev = sd_n;
		while (falls < 2) begin
			advance_cycle();
			if (k % slot_cycles == 0) pcnt = 0;
			if (pixel_clk && pcnt >= 0) pcnt++;
			if (k % slot_cycles == slot_cycles - 1 && pcnt >= 0)
				compare_value("pixel_clk per slot", pcnt, 3);
			if (sd_prev && !sd_n) begin
				if (falls == 0) first_fall = k;
				else compare_value("sd_n period", k - first_fall, frame_cycles);
				falls++;
			end
			sd_prev = sd_n;
		end
	endtask

	// Any window of one frame visits every address once
	task automatic count_blanking();
		int zat_cnt;
		zat_cnt = 0;
		repeat (frame_cycles) begin
			advance_cycle();
			if (k % fetch_cycles == stb_cycle && zat_n) zat_cnt++;
			if (!sr_n) compare_value("zat_n during sr_n", 32'(zat_n), 0);
		end
		compare_value("zat_n fetch count", zat_cnt, 12288);
	endtask

	task automatic check_pixel_order();
		logic [7:0]        byte_q;
		logic [2:0]        n;
		int                lit;
		video_pkg::vaddr_t a;
		byte_q = '0;
		n = 3'd6;  // Idle until the first load
		lit = 0;
		vram0.fill_random();
		mode = color_pkg::green;
		// Border rows show no pixels
		while (!zat_at(k)) begin
			advance_cycle();
		end
		repeat (2048 * fetch_cycles) begin
			if (k % fetch_cycles == stb_cycle) begin
				a = addr_at(k);
				byte_q = vram0.mem[a[13:0]];
				n = 3'd0;
			end
			advance_cycle();
			if (pixel_clk && n < 3'd6) begin
				compare_value("pixel", 32'(pixel), 32'(byte_q[n] & zat_at(k)));
				if (pixel) lit++;
				n = n + 3'd1;
			end
		end
		compare_value("lit pixels seen", 32'(lit > 0), 1);
	endtask

	task automatic sweep_color_mode(input color_pkg::color_mode_e m);
		logic [3:0] seen;  // Attribute values shown on lit pixels
		seen = '0;
		vram0.fill_pattern(8'h00);
		mode = m;
		repeat (1024 * fetch_cycles) begin
			advance_cycle();
			if (pixel) seen[cur_byte[7:6]] = 1'b1;
		end
		compare_value("attributes shown", 32'(seen), 32'hF);
	endtask

	task automatic check_blink(input int frame, input logic lit);
		int pix_cnt;
		int lit_cnt;
		pix_cnt = 0;
		lit_cnt = 0;
		vram0.fill_pattern(8'hBF);  // F2 and all six pixels set
		mode = color_pkg::green;
		while (k / frame_cycles < frame) advance_cycle();
		repeat (256 * fetch_cycles) begin
			advance_cycle();
			if (pixel) begin
				pix_cnt++;
				if (vga_g != 8'h00) lit_cnt++;
			end
		end
		compare_value("blink pixels seen", 32'(pix_cnt > 0), 1);
		compare_value("vga_g lit count", lit_cnt, lit ? pix_cnt : 0);
	endtask

	// --------------------------------------------------
	// Run control
	// --------------------------------------------------

	initial begin
		void'($urandom(32'h9fbd_628b));
		vram0.fill_pattern(8'h00);  // No unknown data on the bus
		reset = 1'b1;
		mode = color_pkg::green;
		k = 0;
		cur_byte = '0;
		pix_idx = '0;
		repeat (2) @(posedge osc);  // Two reset cycles
		@(negedge osc);
		reset = 1'b0;
		verify_outputs();  // Reset state
		check_blink(0, 1'b0);
		check_frame_timing();
		count_blanking();
		check_pixel_order();
		sweep_color_mode(color_pkg::tv);
		sweep_color_mode(color_pkg::rgb);
		sweep_color_mode(color_pkg::reserved);
		check_blink(16, 1'b1);  // Blink bit has toggled
		$display("TEST OK");
		$finish;
	end

	initial begin
		int cycles;
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge osc);
			cycles++;
		end
		$display("TEST FAILED");
		$fatal(1, "Run went past %0d cycles without finishing", cycle_limit);
	end

endmodule

/* bench/vram_model.sv */
`timescale 1ns/100ps

// 16K byte video RAM, answers without delay
module vram_model (
	input  logic [13:0] addr,
	output logic [7:0]  data
);

	logic [7:0] mem [0:16383];

	assign data = mem[addr];  // Combinational read

	// Attributes from the low address bits, pixels from the rest
	task automatic fill_pattern(input logic [7:0] force_bits);
		logic [13:0] ad;
		for (int a = 0; a < 16384; a++) begin
			ad = 14'(a);
			mem[ad] = {ad[1:0], ad[7:2] ^ ad[13:8]} | force_bits;  // Forced bits set high
		end
	endtask

	task automatic fill_random();
		logic [13:0] ad;
		for (int a = 0; a < 16384; a++) begin
			ad = 14'(a);
			mem[ad] = 8'($urandom);
		end
	endtask

endmodule

/* rtl/color_mapper.sv */
`timescale 1ns/100ps

module color_mapper (
	input  logic                    pixel,
	input  color_pkg::pix_attr_t    attr,
	input  logic                    blink,
	input  color_pkg::color_mode_e  color_mode,
	output color_pkg::level_t       vga_r,
	output color_pkg::level_t       vga_g,
	output color_pkg::level_t       vga_b
);

	color_pkg::level_t tv_level;  // Grey for the current attribute
	logic              green_on;  // F2 blanks the pixel in the dark blink phase

	// --------------------------------------------------
	// Grey scale and blink
	// --------------------------------------------------

	always_comb begin
		case (attr)
			2'b00:   tv_level = color_pkg::tv_level_0;
			2'b01:   tv_level = color_pkg::tv_level_1;
			2'b10:   tv_level = color_pkg::tv_level_2;
			default: tv_level = color_pkg::tv_level_3;
		endcase
	end

	assign green_on = ~attr[1] | blink;

	// --------------------------------------------------
	// Mode select
	// --------------------------------------------------

	always_comb begin
		vga_r = '0;
		vga_g = '0;
		vga_b = '0;
		if (pixel) begin
			unique case (color_mode)
				color_pkg::green: begin
					if (green_on) begin
						vga_g = attr[0] ? color_pkg::level_half : color_pkg::level_full;
					end
				end
				color_pkg::tv: begin
					vga_r = tv_level;  // Same level on all three
					vga_g = tv_level;
					vga_b = tv_level;
				end
				color_pkg::rgb: begin
					vga_r = attr[0] ? color_pkg::level_full : '0;  // F1 red
					vga_b = attr[1] ? color_pkg::level_full : '0;  // F2 blue
					vga_g = (attr == 2'b00) ? color_pkg::level_half : '0;
				end
				color_pkg::reserved: begin
					vga_r = '0;  // Black
					vga_g = '0;
					vga_b = '0;
				end
			endcase
		end
	end

endmodule

/* rtl/color_pkg.sv */
package color_pkg;

	// --------------------------------------------------
	// Colour modes and levels
	// --------------------------------------------------

	typedef enum logic [1:0] {
		green    = 2'b00,  // Monochrome green monitor
		tv       = 2'b01,  // Grey levels for a TV set
		rgb      = 2'b10,  // Attribute bits as colours
		reserved = 2'b11   // Shows black
	} color_mode_e;

	typedef logic [7:0] level_t;     // One colour channel
	typedef logic [1:0] pix_attr_t;  // Bit 0 is F1, bit 1 is F2

	localparam level_t level_full = 8'hFF;
	localparam level_t level_half = 8'h80;  // Reduced brightness

	// TV grey scale by attribute value
	localparam level_t tv_level_0 = 8'hFF;  // Normal
	localparam level_t tv_level_1 = 8'hDF;  // Dimmed
	localparam level_t tv_level_2 = 8'hBF;  // Normal with blink
	localparam level_t tv_level_3 = 8'h9F;  // Dimmed with blink

endpackage

/* rtl/pixel_shifter.sv */
`timescale 1ns/100ps

module pixel_shifter (
	input  logic                  osc,
	input  logic                  reset,
	video_timing_if.sink          tif,
	input  logic [7:0]            vram_data,
	input  logic                  zat_n,
	output logic                  pixel,
	output color_pkg::pix_attr_t  attr
);

	logic [5:0] pix_buf;  // Head of the line is bit 0

	// --------------------------------------------------
	// Load and shift
	// --------------------------------------------------

	always_ff @(posedge osc) begin
		if (reset) begin
			pix_buf <= '0;  // Screen dark until the first fetch
			attr    <= '0;
		end else if (tif.stb) begin
			pix_buf <= vram_data[5:0];  // Leftmost pixel is data bit 0
			attr    <= vram_data[7:6];  // F2 and F1
		end else if (tif.pixel_clk) begin
			pix_buf <= {1'b0, pix_buf[5:1]};  // Next pixel to the head
		end
	end

	// Blank outside the display window
	assign pixel = pix_buf[0] & zat_n;

endmodule

/* rtl/pmd_video_top.sv */
`timescale 1ns/100ps

module pmd_video_top (
	input  logic        osc,
	input  logic        reset,
	input  logic [1:0]  color_mode,  // Green, TV, RGB or black
	input  logic [7:0]  vram_data,
	output logic [13:0] vram_addr,
	output logic        pixel_clk,
	output logic        pixel,
	output logic        sd_n,
	output logic        sr_n,
	output logic        zat_n,
	output logic [7:0]  vga_r,
	output logic [7:0]  vga_g,
	output logic [7:0]  vga_b
);

	video_timing_if tif ();  // Slot strobes

	video_pkg::vaddr_t      vaddr;
	logic                   blink;
	color_pkg::pix_attr_t   attr;
	color_pkg::color_mode_e mode;

	assign mode      = color_pkg::color_mode_e'(color_mode);
	assign pixel_clk = tif.pixel_clk;  // Dot clock for the scan converter

	// --------------------------------------------------
	// Timing and address
	// --------------------------------------------------

	slot_sequencer seq0 (
		.osc   (osc),
		.reset (reset),
		.tif   (tif.source)
	);

	refresh_counter rcnt0 (
		.osc       (osc),
		.reset     (reset),
		.tif       (tif.sink),
		.vaddr     (vaddr),
		.vram_addr (vram_addr),
		.blink     (blink)
	);

	raster_sync sync0 (
		.osc   (osc),
		.reset (reset),
		.tif   (tif.sink),
		.vaddr (vaddr),
		.sd_n  (sd_n),
		.sr_n  (sr_n),
		.zat_n (zat_n)
	);

	// --------------------------------------------------
	// Pixel path
	// --------------------------------------------------

	pixel_shifter shift0 (
		.osc       (osc),
		.reset     (reset),
		.tif       (tif.sink),
		.vram_data (vram_data),
		.zat_n     (zat_n),
		.pixel     (pixel),
		.attr      (attr)
	);

	color_mapper cmap0 (
		.pixel      (pixel),
		.attr       (attr),
		.blink      (blink),
		.color_mode (mode),
		.vga_r      (vga_r),
		.vga_g      (vga_g),
		.vga_b      (vga_b)
	);

endmodule

/* rtl/raster_sync.sv */
`timescale 1ns/100ps

module raster_sync (
	input  logic              osc,
	input  logic              reset,
	video_timing_if.sink      tif,
	input  video_pkg::vaddr_t vaddr,
	output logic              sd_n,   // Vertical sync
	output logic              sr_n,   // Horizontal sync
	output logic              zat_n   // High while the display is on
);

	logic       stb_d;
	logic       row_active;  // Inside the visible part of a row
	logic [5:0] next_pos;    // Row position the address moves to

	// Frame wrap lands on a multiple of 64 too
	assign next_pos = vaddr[5:0] + 6'd1;

	// --------------------------------------------------
	// Row window
	// --------------------------------------------------

	// Clocked form of the old set/reset latch
	// It moves on the same edge as the address
	always_ff @(posedge osc) begin
		if (reset) begin
			stb_d      <= 1'b0;
			row_active <= 1'b0;
		end else begin
			stb_d <= tif.stb;
			if (stb_d) begin
				if (next_pos == video_pkg::row_clr_pos) begin
					row_active <= 1'b0;  // Past the right edge
				end else if (next_pos == video_pkg::row_set_pos) begin
					row_active <= 1'b1;  // Row starts
				end
			end
		end
	end

	// --------------------------------------------------
	// Sync and blanking decode
	// --------------------------------------------------

	// Rows 288 to 291 of the bottom border
	assign sd_n = ~((vaddr[10:8] == 3'b000) & vaddr[11] & vaddr[14]);

	// Once per row in the right border
	assign sr_n = ~(vaddr[2] & ~vaddr[3] & ~row_active);

	// Upper 16K is border only
	assign zat_n = ~vaddr[14] & row_active;

endmodule

/* rtl/refresh_counter.sv */
`timescale 1ns/100ps

module refresh_counter (
	input  logic                   osc,
	input  logic                   reset,
	video_timing_if.sink           tif,
	output video_pkg::vaddr_t      vaddr,
	output video_pkg::vram_addr_t  vram_addr,
	output logic                   blink
);

	logic                  stb_d;       // Cycle after the strobe
	video_pkg::vaddr_t     vaddr_next;
	video_pkg::frame_cnt_t frame_cnt;   // Replaces the counter on address bit 9

	assign vaddr_next = vaddr + 15'd1;

	// --------------------------------------------------
	// Address and frame count
	// --------------------------------------------------

	// Address moves at the end of the video slot
	// so it holds for the whole slot
	always_ff @(posedge osc) begin
		if (reset) begin
			stb_d     <= 1'b0;
			vaddr     <= '0;
			frame_cnt <= '0;
		end else begin
			stb_d <= tif.stb;
			if (stb_d) begin
				if (vaddr_next == video_pkg::frame_fetches) begin
					vaddr     <= '0;                 // Frame wrap
					frame_cnt <= frame_cnt + 8'd1;
				end else begin
					vaddr <= vaddr_next;
				end
			end
		end
	end

	assign vram_addr = vaddr[13:0];  // Top bit is not a RAM line

	// Slow toggle for blinking attributes
	assign blink = frame_cnt[video_pkg::blink_frame_bit];

endmodule

/* rtl/slot_sequencer.sv */
`timescale 1ns/100ps

module slot_sequencer (
	input logic osc,
	input logic reset,
	video_timing_if.source tif
);

	video_pkg::slot_cnt_t slot_count;  // 0 to 8
	logic                 phi2;        // Phi2 pattern of the slot
	logic [7:0]           clk_shift;   // Eight tap chain, as the old 74LS164
	logic                 video_slot;
	logic                 dot_phase;   // Decoded tap pattern
	logic                 dot_phase_d;

	assign phi2 = (slot_count >= 4'd1) && (slot_count <= 4'd5);

	// --------------------------------------------------
	// Slot counter and slot toggle
	// --------------------------------------------------

	always_ff @(posedge osc) begin
		if (reset) begin
			slot_count <= '0;
			video_slot <= 1'b0;  // CPU slot first
		end else if (slot_count == video_pkg::slot_len - 4'd1) begin
			slot_count <= '0;
			video_slot <= ~video_slot;  // Alternate CPU and video
		end else begin
			slot_count <= slot_count + 4'd1;
		end
	end

	// --------------------------------------------------
	// Tap chain and pixel clock
	// --------------------------------------------------

	// Chain fills within the first slot
	always_ff @(posedge osc) begin
		if (reset) begin
			clk_shift   <= '0;
			dot_phase_d <= 1'b0;
		end else begin
			clk_shift   <= {clk_shift[6:0], phi2};
			dot_phase_d <= dot_phase;
		end
	end

	// Same three gates as the board
	// High at counts 0, 3, 4, 6 and 7
	assign dot_phase = (clk_shift[1] & clk_shift[7])
		| (clk_shift[1] & clk_shift[4])
		| (clk_shift[3] & clk_shift[7]);

	// Rising edge of the decode gives counts 0, 3 and 6
	assign tif.pixel_clk = dot_phase & ~dot_phase_d;

	assign tif.amux       = clk_shift[7];  // Follows the last tap
	assign tif.video_slot = video_slot;
	assign tif.stb        = video_slot && (slot_count == video_pkg::stb_count);  // Count 7 only

endmodule

/* rtl/video_pkg.sv */
package video_pkg;

	// --------------------------------------------------
	// Address and counter types
	// --------------------------------------------------

	typedef logic [14:0] vaddr_t;      // Refresh and video address
	typedef logic [13:0] vram_addr_t;  // 16K byte video RAM
	typedef logic [3:0]  slot_cnt_t;   // Position inside one bus slot
	typedef logic [7:0]  frame_cnt_t;  // Frames since reset

	// --------------------------------------------------
	// Raster timing
	// --------------------------------------------------

	// One bus slot is nine osc cycles
	// CPU and video slots alternate
	localparam slot_cnt_t slot_len  = 4'd9;
	localparam slot_cnt_t stb_count = 4'd7;   // Data strobe inside a video slot

	// 320 rows of 64 fetches
	// The address runs to 0x5000 and starts over
	localparam vaddr_t frame_fetches = 15'd20480;

	// Row window inside 64 fetches
	// 48 fetches of six pixels give 288 visible pixels
	localparam logic [5:0] row_set_pos = 6'd1;
	localparam logic [5:0] row_clr_pos = 6'd49;

	// Frame counter bit that drives blink
	// Bit 4 toggles every 16 frames
	localparam int blink_frame_bit = 4;

endpackage

/* rtl/video_timing_if.sv */
`timescale 1ns/100ps

// Slot strobes from the sequencer
// All pulses are one osc cycle wide
interface video_timing_if;

	logic video_slot;  // High for the whole video slot
	logic amux;        // Row or column phase of the DRAM address
	logic stb;         // Video data strobe
	logic pixel_clk;   // Three per slot

	modport source (
		output video_slot,
		output amux,
		output stb,
		output pixel_clk
	);

	modport sink (
		input video_slot,
		input amux,
		input stb,
		input pixel_clk
	);

endinterface

/* run.sh */
#!/bin/sh
# Build the raster engine testbench and run it
# The exit status of the simulation is the test result
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 -f vlog.f --top-module tb_pmd_video -o sim_pmd_video
./obj_dir/sim_pmd_video

/* vlog.f */
rtl/video_pkg.sv
rtl/color_pkg.sv
rtl/video_timing_if.sv
rtl/slot_sequencer.sv
rtl/refresh_counter.sv
rtl/raster_sync.sv
rtl/pixel_shifter.sv
rtl/color_mapper.sv
rtl/pmd_video_top.sv
bench/vram_model.sv
bench/tb_pmd_video.sv
